// ==== verilog/dcachePkg.sv ====
package dcachePkg;

  // address split and geometry
  localparam int AddrWidth    = 32;
  localparam int Xlen         = 64;
  localparam int NumWays      = 2;
  localparam int IndexWidth   = 6;
  localparam int OffsetWidth  = 5;
  localparam int TagWidth     = AddrWidth - IndexWidth - OffsetWidth;
  localparam int LineWidth    = 256;
  localparam int BeatsPerLine = LineWidth / Xlen;

  // derived sizes
  localparam int NumSets      = 1 << IndexWidth;
  localparam int ByteLanes    = Xlen / 8;
  localparam int ByteIdxWidth = $clog2(ByteLanes);
  localparam int WordIdxWidth = $clog2(BeatsPerLine);
  localparam int WayIdxWidth  = (NumWays > 1) ? $clog2(NumWays) : 1;

  // replacement lfsr, x^16 + x^14 + x^13 + x^11
  localparam int                   LfsrWidth = 16;
  localparam logic [LfsrWidth-1:0] LfsrSeed  = 16'hACE1;

  typedef enum logic {
    OpLoad  = 1'b0,
    OpStore = 1'b1
  } cacheOpE;

  typedef enum logic [2:0] {
    StIdle      = 3'd0,
    StCompare   = 3'd1,
    StWriteBack = 3'd2,
    StMissReq   = 3'd3,
    StRefill    = 3'd4,
    StReplace   = 3'd5
  } ctrlStateE;

endpackage

// ==== verilog/dcacheWayIf.sv ====
interface dcacheWayIf import dcachePkg::*; (
  input logic clk,
  input logic rst_n
);

  // request side, from the controller
  logic [IndexWidth-1:0]   index;
  logic [TagWidth-1:0]     reqTag;
  logic [WordIdxWidth-1:0] wordSel;
  logic [NumWays-1:0]      fillWay;
  logic [NumWays-1:0]      storeWay;
  logic [LineWidth-1:0]    fillLine;
  logic [LineWidth-1:0]    storeLine;
  logic [LineWidth-1:0]    storeBitMask;
  logic [WayIdxWidth-1:0]  victimWay;

  // per-way lookup results, one slot per way
  logic [NumWays-1:0]      wayHit;
  logic [NumWays-1:0]      wayDirty;
  logic [NumWays-1:0]      wayValid;
  logic [TagWidth-1:0]     wayTag [NumWays];
  logic [LineWidth-1:0]    wayLine [NumWays];

  // merged view
  logic                    anyHit;
  logic [WayIdxWidth-1:0]  hitWay;
  logic [Xlen-1:0]         loadWord;
  logic [LineWidth-1:0]    victimLine;
  logic [AddrWidth-1:0]    victimAddr;
  logic                    victimDirty;

  modport ctrl (
    output index, reqTag, wordSel, fillWay, storeWay, fillLine, storeLine, storeBitMask,
    output victimWay,
    input  wayValid, anyHit, hitWay, loadWord, victimLine, victimAddr, victimDirty
  );

  modport way (
    input  index, reqTag, fillWay, storeWay, fillLine, storeLine, storeBitMask,
    output wayHit, wayDirty, wayValid, wayTag, wayLine
  );

  modport merge (
    input  clk, rst_n, index, wordSel, victimWay,
    input  wayHit, wayDirty, wayValid, wayTag, wayLine,
    output anyHit, hitWay, loadWord, victimLine, victimAddr, victimDirty
  );

endinterface

// ==== verilog/dcacheWay.sv ====
module dcacheWay import dcachePkg::*; #(
  parameter int WayIdx = 0
) (
  input  logic     clk,
  input  logic     rst_n,
  dcacheWayIf.way  wayBus
);

  logic [NumSets-1:0]   validQ;
  logic [NumSets-1:0]   dirtyQ;
  logic [TagWidth-1:0]  tagMem [NumSets];
  logic [LineWidth-1:0] lineMem [NumSets];

  logic [IndexWidth-1:0] idx;
  logic                  fillEn;
  logic                  storeEn;
  logic [TagWidth-1:0]   curTag;
  logic [LineWidth-1:0]  curLine;
  logic [LineWidth-1:0]  mergedLine;

  assign idx     = wayBus.index;
  assign fillEn  = wayBus.fillWay[WayIdx];
  assign storeEn = wayBus.storeWay[WayIdx];

  // combinational read of the addressed set
  assign curTag  = tagMem[idx];
  assign curLine = lineMem[idx];

  // store keeps unmasked bits of the resident line
  assign mergedLine = (curLine & ~wayBus.storeBitMask) |
                      (wayBus.storeLine & wayBus.storeBitMask);

  // state bits per set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
    end else if (fillEn) begin
      validQ[idx] <= 1'b1;
      dirtyQ[idx] <= 1'b0;
    end else if (storeEn) begin
      dirtyQ[idx] <= 1'b1;
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    if (fillEn) begin
      tagMem[idx]  <= wayBus.reqTag;
      lineMem[idx] <= wayBus.fillLine;
    end else if (storeEn) begin
      lineMem[idx] <= mergedLine;
    end
  end

  // report into this way's slot
  assign wayBus.wayValid[WayIdx] = validQ[idx];
  assign wayBus.wayDirty[WayIdx] = dirtyQ[idx];
  assign wayBus.wayTag[WayIdx]   = curTag;
  assign wayBus.wayLine[WayIdx]  = curLine;
  assign wayBus.wayHit[WayIdx]   = validQ[idx] && (curTag == wayBus.reqTag);

endmodule

// ==== verilog/dcacheWayMerge.sv ====
module dcacheWayMerge import dcachePkg::*; (
  dcacheWayIf.merge wayBus
);

  logic [WayIdxWidth-1:0] hitIdx;
  logic [LineWidth-1:0]   hitLine;
  logic [TagWidth-1:0]    victimTag;

  // encode the hitting way
  always_comb begin
    hitIdx = '0;
    for (int w = 0; w < NumWays; w++) begin
      if (wayBus.wayHit[w]) begin
        hitIdx = WayIdxWidth'(w);
      end
    end
  end

  assign wayBus.anyHit = |wayBus.wayHit;
  assign wayBus.hitWay = hitIdx;

  // load word picked by offset bits 4:3
  assign hitLine         = wayBus.wayLine[hitIdx];
  assign wayBus.loadWord = hitLine[wayBus.wordSel*Xlen +: Xlen];

  // victim as named by the controller
  assign victimTag         = wayBus.wayTag[wayBus.victimWay];
  assign wayBus.victimLine = wayBus.wayLine[wayBus.victimWay];
  assign wayBus.victimAddr = {victimTag, wayBus.index, OffsetWidth'(0)};

  // only a valid line can need a write-back
  assign wayBus.victimDirty = wayBus.wayValid[wayBus.victimWay] &&
                              wayBus.wayDirty[wayBus.victimWay];

  // a tag lives in one way only, so fills never duplicate a line
  oneHitWay: assert property (@(posedge wayBus.clk) disable iff (!wayBus.rst_n)
    $onehot0(wayBus.wayHit));

endmodule

// ==== verilog/dcacheCtrl.sv ====
module dcacheCtrl import dcachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // pipeline side
  input  logic [AddrWidth-1:0]  addr_i,
  input  logic                  valid_i,
  input  cacheOpE               op_i,
  input  logic [Xlen-1:0]       wrData_i,
  input  logic [ByteLanes-1:0]  wrMask_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output logic                  dataNotOk_o,
  output logic [Xlen-1:0]       rdData_o,
  // memory read side
  output logic                  cacheRdValid_o,
  output logic [AddrWidth-1:0]  cacheRdAddr_o,
  input  logic                  axiRdReady_i,
  input  logic [Xlen-1:0]       rdData_i,
  input  logic                  dataValid_i,
  input  logic                  rdLast_i,
  // memory write side
  output logic                  cacheWrValid_o,
  output logic [AddrWidth-1:0]  cacheWrAddr_o,
  output logic [LineWidth-1:0]  cacheWrData_o,
  input  logic                  axiWrReady_i,
  dcacheWayIf.ctrl              wayBus
);

  ctrlStateE stateQ;
  ctrlStateE stateD;

  logic [AddrWidth-1:0]    reqAddrQ;
  cacheOpE                 reqOpQ;
  logic [Xlen-1:0]         reqDataQ;
  logic [ByteLanes-1:0]    reqMaskQ;
  logic [WordIdxWidth-1:0] beatCntQ;
  logic [LineWidth-1:0]    refillBuf;
  logic [LfsrWidth-1:0]    lfsrQ;
  logic [WayIdxWidth-1:0]  victimPick;
  logic [WayIdxWidth-1:0]  victimWayQ;
  logic [Xlen-1:0]         wordMask;
  logic [WordIdxWidth-1:0] wordSel;
  logic [IndexWidth-1:0]   reqIndex;
  logic [TagWidth-1:0]     reqTag;

  logic inCompare;
  logic compareHit;
  logic compareMiss;
  logic accept;
  logic refillBeat;

  assign inCompare   = (stateQ == StCompare);
  assign compareHit  = inCompare && wayBus.anyHit;
  assign compareMiss = inCompare && !wayBus.anyHit;
  assign refillBeat  = (stateQ == StRefill) && dataValid_i;

  // a hit in compare frees the slot for the next request
  assign addrOk_o = (stateQ == StIdle) || compareHit;
  assign accept   = valid_i && addrOk_o;

  // request split
  assign reqIndex = reqAddrQ[OffsetWidth +: IndexWidth];
  assign reqTag   = reqAddrQ[AddrWidth-1 -: TagWidth];
  assign wordSel  = reqAddrQ[ByteIdxWidth +: WordIdxWidth];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= StIdle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      StIdle: begin
        if (accept) begin
          stateD = StCompare;
        end
      end
      StCompare: begin
        if (wayBus.anyHit) begin
          stateD = accept ? StCompare : StIdle;
        end else begin
          // dirty victim goes out before the refill is asked for
          stateD = wayBus.victimDirty ? StWriteBack : StMissReq;
        end
      end
      StWriteBack: begin
        if (axiWrReady_i) begin
          stateD = StMissReq;
        end
      end
      StMissReq: begin
        if (axiRdReady_i) begin
          stateD = StRefill;
        end
      end
      StRefill: begin
        if (dataValid_i && rdLast_i) begin
          stateD = StReplace;
        end
      end
      StReplace: begin
        stateD = StCompare;
      end
      default: begin
        stateD = StIdle;
      end
    endcase
  end

  // request latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddrQ <= '0;
      reqOpQ   <= OpLoad;
    end else if (accept) begin
      reqAddrQ <= addr_i;
      reqOpQ   <= op_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqDataQ <= wrData_i;
      reqMaskQ <= wrMask_i;
    end
  end

  // refill beats land in consecutive word slots
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCntQ <= '0;
    end else if (stateQ == StMissReq) begin
      beatCntQ <= '0;
    end else if (refillBeat) begin
      beatCntQ <= beatCntQ + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refillBeat) begin
      refillBuf[beatCntQ*Xlen +: Xlen] <= rdData_i;
    end
  end

  // free-running replacement source
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsrQ <= LfsrSeed;
    end else begin
      lfsrQ <= {lfsrQ[LfsrWidth-2:0], lfsrQ[15] ^ lfsrQ[13] ^ lfsrQ[12] ^ lfsrQ[10]};
    end
  end

  // lowest invalid way wins over the random pick
  always_comb begin
    victimPick = WayIdxWidth'(lfsrQ % NumWays);
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!wayBus.wayValid[w]) begin
        victimPick = WayIdxWidth'(w);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimWayQ <= '0;
    end else if (compareMiss) begin
      victimWayQ <= victimPick;
    end
  end

  // byte mask to bit mask over one word
  always_comb begin
    wordMask = '0;
    for (int b = 0; b < ByteLanes; b++) begin
      wordMask[b*8 +: 8] = {8{reqMaskQ[b]}};
    end
  end

  // way write enables
  always_comb begin
    wayBus.fillWay  = '0;
    wayBus.storeWay = '0;
    if (stateQ == StReplace) begin
      wayBus.fillWay[victimWayQ] = 1'b1;
    end
    if (compareHit && (reqOpQ == OpStore)) begin
      wayBus.storeWay[wayBus.hitWay] = 1'b1;
    end
  end

  assign wayBus.index        = reqIndex;
  assign wayBus.reqTag       = reqTag;
  assign wayBus.wordSel      = wordSel;
  assign wayBus.fillLine     = refillBuf;
  assign wayBus.storeLine    = LineWidth'(reqDataQ) << (wordSel * Xlen);
  assign wayBus.storeBitMask = LineWidth'(wordMask) << (wordSel * Xlen);
  assign wayBus.victimWay    = inCompare ? victimPick : victimWayQ;

  // pipeline results
  assign dataOk_o    = compareHit;
  assign dataNotOk_o = compareMiss || (stateQ == StWriteBack) || (stateQ == StMissReq) ||
                       (stateQ == StRefill) || (stateQ == StReplace);
  assign rdData_o    = (compareHit && (reqOpQ == OpLoad)) ? wayBus.loadWord : '0;

  // memory port
  assign cacheRdValid_o = (stateQ == StMissReq);
  assign cacheRdAddr_o  = {reqTag, reqIndex, OffsetWidth'(0)};
  assign cacheWrValid_o = (stateQ == StWriteBack);
  assign cacheWrAddr_o  = wayBus.victimAddr;
  assign cacheWrData_o  = wayBus.victimLine;

  // one memory channel busy at a time
  rdWrExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(cacheRdValid_o && cacheWrValid_o));

  okOnlyInCompare: assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_o |-> stateQ == StCompare);

endmodule

// ==== verilog/dcacheTop.sv ====
module dcacheTop import dcachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // pipeline side
  input  logic [AddrWidth-1:0]  addr_i,
  input  logic                  valid_i,
  input  cacheOpE               op_i,
  input  logic [Xlen-1:0]       wrData_i,
  input  logic [ByteLanes-1:0]  wrMask_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output logic                  dataNotOk_o,
  output logic [Xlen-1:0]       rdData_o,
  // memory read side
  output logic                  cacheRdValid_o,
  output logic [AddrWidth-1:0]  cacheRdAddr_o,
  input  logic                  axiRdReady_i,
  input  logic [Xlen-1:0]       rdData_i,
  input  logic                  dataValid_i,
  input  logic                  rdLast_i,
  // memory write side
  output logic                  cacheWrValid_o,
  output logic [AddrWidth-1:0]  cacheWrAddr_o,
  output logic [LineWidth-1:0]  cacheWrData_o,
  input  logic                  axiWrReady_i
);

  dcacheWayIf wayBus (
    .clk   (clk),
    .rst_n (rst_n)
  );

  dcacheCtrl i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_i         (addr_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .wrData_i       (wrData_i),
    .wrMask_i       (wrMask_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .dataNotOk_o    (dataNotOk_o),
    .rdData_o       (rdData_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheRdAddr_o  (cacheRdAddr_o),
    .axiRdReady_i   (axiRdReady_i),
    .rdData_i       (rdData_i),
    .dataValid_i    (dataValid_i),
    .rdLast_i       (rdLast_i),
    .cacheWrValid_o (cacheWrValid_o),
    .cacheWrAddr_o  (cacheWrAddr_o),
    .cacheWrData_o  (cacheWrData_o),
    .axiWrReady_i   (axiWrReady_i),
    .wayBus         (wayBus.ctrl)
  );

  // identical ways, each reporting into its own slot
  for (genvar w = 0; w < NumWays; w++) begin : g_way
    dcacheWay #(
      .WayIdx (w)
    ) i_way (
      .clk    (clk),
      .rst_n  (rst_n),
      .wayBus (wayBus.way)
    );
  end

  dcacheWayMerge i_merge (
    .wayBus (wayBus.merge)
  );

endmodule

// ==== tb/dcacheTb.sv ====
module dcacheTb import dcachePkg::*; ();

  localparam int NumReq    = 600;
  localparam int ClkPeriod = 10;
  localparam int TagBase   = 32'h1F00;

  logic                 clk;
  logic                 rst_n;
  logic [AddrWidth-1:0] addr_i;
  logic                 valid_i;
  cacheOpE              op_i;
  logic [Xlen-1:0]      wrData_i;
  logic [ByteLanes-1:0] wrMask_i;
  logic                 addrOk_o;
  logic                 dataOk_o;
  logic                 dataNotOk_o;
  logic [Xlen-1:0]      rdData_o;
  logic                 cacheRdValid_o;
  logic [AddrWidth-1:0] cacheRdAddr_o;
  logic                 axiRdReady_i;
  logic [Xlen-1:0]      rdData_i;
  logic                 dataValid_i;
  logic                 rdLast_i;
  logic                 cacheWrValid_o;
  logic [AddrWidth-1:0] cacheWrAddr_o;
  logic [LineWidth-1:0] cacheWrData_o;
  logic                 axiWrReady_i;

  // backing memory by line, reference model by byte
  logic [LineWidth-1:0] backMem   [bit [AddrWidth-1:0]];
  logic [7:0]           modelMem  [bit [AddrWidth-1:0]];
  bit                   dirtyLine [bit [AddrWidth-1:0]];
  bit                   seenLine  [bit [AddrWidth-1:0]];

  int                   issued;
  int                   completed;
  int                   waitCycles;
  int                   doneAt;
  int                   beatIdx;
  bit                   pending;
  bit                   expectHit;
  bit                   expectMiss;
  bit                   haveLast;
  bit                   refillActive;
  bit                   refillAsked;
  logic [AddrWidth-1:0] curAddr;
  logic [AddrWidth-1:0] lastAddr;
  cacheOpE              curOp;
  logic [Xlen-1:0]      curData;
  logic [ByteLanes-1:0] curMask;
  logic [LineWidth-1:0] refillLine;

  dcacheTop i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_i         (addr_i),
    .valid_i        (valid_i),
    .op_i           (op_i),
    .wrData_i       (wrData_i),
    .wrMask_i       (wrMask_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .dataNotOk_o    (dataNotOk_o),
    .rdData_o       (rdData_o),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheRdAddr_o  (cacheRdAddr_o),
    .axiRdReady_i   (axiRdReady_i),
    .rdData_i       (rdData_i),
    .dataValid_i    (dataValid_i),
    .rdLast_i       (rdLast_i),
    .cacheWrValid_o (cacheWrValid_o),
    .cacheWrAddr_o  (cacheWrAddr_o),
    .cacheWrData_o  (cacheWrData_o),
    .axiWrReady_i   (axiWrReady_i)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic stopRun();
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkLoadWord(input logic [Xlen-1:0] exp, input logic [Xlen-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: rdData_o expected %h, got %h", $time, exp, act);
      stopRun();
    end
  endtask

  task automatic checkWbLine(input logic [AddrWidth-1:0] expAddr,
                             input logic [AddrWidth-1:0] actAddr,
                             input logic [LineWidth-1:0] expLine,
                             input logic [LineWidth-1:0] actLine);
    if (actAddr !== expAddr) begin
      $display("Fail at %0t: cacheWrAddr_o expected %h, got %h", $time, expAddr, actAddr);
      stopRun();
    end
    if (actLine !== expLine) begin
      $display("Fail at %0t: cacheWrData_o expected %h, got %h", $time, expLine, actLine);
      stopRun();
    end
  endtask

  task automatic checkRdAddr(input logic [AddrWidth-1:0] exp, input logic [AddrWidth-1:0] act);
    if (act !== exp) begin
      $display("Fail at %0t: cacheRdAddr_o expected %h, got %h", $time, exp, act);
      stopRun();
    end
  endtask

  task automatic checkAddrOk(input logic exp);
    if (addrOk_o !== exp) begin
      $display("Fail at %0t: addrOk_o expected %b, got %b", $time, exp, addrOk_o);
      stopRun();
    end
  endtask

  task automatic checkCtrlBit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      stopRun();
    end
  endtask

  function automatic logic [AddrWidth-1:0] lineOf(input logic [AddrWidth-1:0] a);
    return {a[AddrWidth-1:OffsetWidth], OffsetWidth'(0)};
  endfunction

  // initial memory contents, a function of the full word address
  function automatic logic [Xlen-1:0] fillWord(input logic [AddrWidth-1:0] a);
    return {~a, a * 32'h9E37_79B9};
  endfunction

  function automatic logic [LineWidth-1:0] backLine(input logic [AddrWidth-1:0] la);
    logic [LineWidth-1:0] line;
    if (backMem.exists(la)) begin
      return backMem[la];
    end
    for (int k = 0; k < BeatsPerLine; k++) begin
      line[k*Xlen +: Xlen] = fillWord(la + AddrWidth'(k * ByteLanes));
    end
    return line;
  endfunction

  function automatic logic [7:0] modelByte(input logic [AddrWidth-1:0] a);
    logic [Xlen-1:0] w;
    if (modelMem.exists(a)) begin
      return modelMem[a];
    end
    w = fillWord({a[AddrWidth-1:ByteIdxWidth], ByteIdxWidth'(0)});
    return w[a[ByteIdxWidth-1:0]*8 +: 8];
  endfunction

  function automatic logic [Xlen-1:0] modelWord(input logic [AddrWidth-1:0] a);
    logic [Xlen-1:0] w;
    for (int i = 0; i < ByteLanes; i++) begin
      w[i*8 +: 8] = modelByte(a + AddrWidth'(i));
    end
    return w;
  endfunction

  function automatic logic [LineWidth-1:0] modelLine(input logic [AddrWidth-1:0] la);
    logic [LineWidth-1:0] line;
    for (int k = 0; k < BeatsPerLine; k++) begin
      line[k*Xlen +: Xlen] = modelWord(la + AddrWidth'(k * ByteLanes));
    end
    return line;
  endfunction

  // 16 tags over 4 sets, enough to force evictions
  function automatic logic [AddrWidth-1:0] randomAddr();
    return {TagWidth'(TagBase + ($urandom % 16)), IndexWidth'($urandom % 4),
            WordIdxWidth'($urandom % BeatsPerLine), ByteIdxWidth'(0)};
  endfunction

  task automatic applyStore();
    for (int b = 0; b < ByteLanes; b++) begin
      if (curMask[b]) begin
        modelMem[curAddr + AddrWidth'(b)] = curData[b*8 +: 8];
      end
    end
    dirtyLine[lineOf(curAddr)] = 1'b1;
  endtask

  task automatic checkResponse();
    logic known;
    logic expDone;
    if (pending) begin
      waitCycles++;
      // hits answer in the first cycle and refills two cycles after the last beat
      if (waitCycles == 1) begin
        known   = expectHit || expectMiss;
        expDone = expectHit;
      end else begin
        known   = 1'b1;
        expDone = (waitCycles == doneAt);
      end
      if (known) begin
        checkCtrlBit("dataOk_o", expDone, dataOk_o);
        checkAddrOk(expDone);
      end
      if (dataOk_o) begin
        checkCtrlBit("dataNotOk_o", 1'b0, dataNotOk_o);
        if (curOp == OpLoad) begin
          checkLoadWord(modelWord(curAddr), rdData_o);
        end else begin
          checkLoadWord('0, rdData_o);
          applyStore();
        end
        completed++;
        pending  = 1'b0;
        lastAddr = curAddr;
        haveLast = 1'b1;
      end else begin
        checkCtrlBit("dataNotOk_o", 1'b1, dataNotOk_o);
      end
    end else begin
      if (dataOk_o) begin
        $display("dataOk_o was raised at %0t with no request outstanding", $time);
        stopRun();
      end
      checkAddrOk(1'b1);
    end
  endtask

  task automatic serveWrite();
    logic [AddrWidth-1:0] wbAddr;
    axiWrReady_i = 1'b0;
    if (cacheWrValid_o && refillAsked) begin
      $display("write-back at %0t came after the refill request of the same miss", $time);
      stopRun();
    end
    if (cacheWrValid_o && ($urandom % 3 == 0)) begin
      wbAddr = cacheWrAddr_o;
      checkWbLine({wbAddr[AddrWidth-1 -: TagWidth], curAddr[OffsetWidth +: IndexWidth],
                   OffsetWidth'(0)}, wbAddr, modelLine(wbAddr), cacheWrData_o);
      if (!dirtyLine.exists(wbAddr) || !dirtyLine[wbAddr]) begin
        $display("write-back at %0t of line %h that had no store since its fill", $time, wbAddr);
        stopRun();
      end
      backMem[wbAddr]   = cacheWrData_o;
      dirtyLine[wbAddr] = 1'b0;
      axiWrReady_i      = 1'b1;
    end
  endtask

  task automatic serveRead();
    dataValid_i  = 1'b0;
    rdLast_i     = 1'b0;
    axiRdReady_i = 1'b0;
    rdData_i     = {$urandom, $urandom};
    if (refillActive && ($urandom % 3 != 0)) begin
      dataValid_i = 1'b1;
      rdData_i    = refillLine[beatIdx*Xlen +: Xlen];
      rdLast_i    = (beatIdx == BeatsPerLine - 1);
      beatIdx++;
      if (beatIdx == BeatsPerLine) begin
        refillActive = 1'b0;
        doneAt       = waitCycles + 2;
      end
    end else if (!refillActive && cacheRdValid_o && ($urandom % 2 == 0)) begin
      checkRdAddr(lineOf(curAddr), cacheRdAddr_o);
      if (dirtyLine.exists(cacheRdAddr_o) && dirtyLine[cacheRdAddr_o]) begin
        $display("refill at %0t of line %h whose stores were never written back",
                 $time, cacheRdAddr_o);
        stopRun();
      end
      refillLine   = backLine(cacheRdAddr_o);
      beatIdx      = 0;
      refillActive = 1'b1;
      refillAsked  = 1'b1;
      axiRdReady_i = 1'b1;
    end
  endtask

  task automatic driveRequest();
    valid_i = 1'b0;
    if (!pending && issued < NumReq && ($urandom % 4 != 0)) begin
      expectHit = haveLast && ($urandom % 4 == 0);
      if (expectHit) begin
        curAddr = lastAddr;
        curOp   = OpLoad;
      end else begin
        curAddr = randomAddr();
        curOp   = ($urandom % 2 == 0) ? OpLoad : OpStore;
      end
      curData    = {$urandom, $urandom};
      curMask    = ByteLanes'($urandom);
      expectMiss = !seenLine.exists(lineOf(curAddr));
      seenLine[lineOf(curAddr)] = 1'b1;
      addr_i      = curAddr;
      op_i        = curOp;
      wrData_i    = curData;
      wrMask_i    = curMask;
      valid_i     = 1'b1;
      pending     = 1'b1;
      waitCycles  = 0;
      doneAt      = 0;
      refillAsked = 1'b0;
      issued++;
    end
  endtask

  initial begin
    repeat (NumReq * 200) @(posedge clk);
    $display("watchdog expired with %0d of %0d requests completed", completed, NumReq);
    stopRun();
  end

  initial begin
    void'($urandom(21));
    rst_n        = 1'b0;
    addr_i       = '0;
    valid_i      = 1'b0;
    op_i         = OpLoad;
    wrData_i     = '0;
    wrMask_i     = '0;
    axiRdReady_i = 1'b0;
    rdData_i     = '0;
    dataValid_i  = 1'b0;
    rdLast_i     = 1'b0;
    axiWrReady_i = 1'b0;
    issued       = 0;
    completed    = 0;
    doneAt       = 0;
    pending      = 1'b0;
    haveLast     = 1'b0;
    refillActive = 1'b0;
    refillAsked  = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // idle outputs out of reset
    checkAddrOk(1'b1);
    checkCtrlBit("dataOk_o", 1'b0, dataOk_o);
    checkCtrlBit("dataNotOk_o", 1'b0, dataNotOk_o);
    checkCtrlBit("cacheRdValid_o", 1'b0, cacheRdValid_o);
    checkCtrlBit("cacheWrValid_o", 1'b0, cacheWrValid_o);
    while (completed < NumReq) begin
      checkResponse();
      serveWrite();
      serveRead();
      driveRequest();
      @(negedge clk);
    end
    // no late completions once traffic stops
    repeat (4) begin
      checkResponse();
      @(negedge clk);
    end
    if (completed == issued && !pending) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("%0d requests issued but %0d completed", issued, completed);
      stopRun();
    end
  end

endmodule

// ==== dcacheTop.f ====
verilog/dcachePkg.sv
verilog/dcacheWayIf.sv
verilog/dcacheWay.sv
verilog/dcacheWayMerge.sv
verilog/dcacheCtrl.sv
verilog/dcacheTop.sv
tb/dcacheTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dcache testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --assert --top-module dcacheTb \
  -Mdir "$BUILD" -f dcacheTop.f

# exit code of the simulator is not used, the log is scanned below
"./$BUILD/VdcacheTb" | tee "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if ! grep -q "Test completed successfully" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"
